// ==== files.f ====
rv_isa_pkg.sv
core_pkg.sv
issue_queue.sv
decoder.sv
regfile.sv
ex.sv
lsu.sv
exec_core.sv
tb_exec_core.sv

// ==== Makefile ====
TOP = tb_exec_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module exec_core -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== tb_exec_core.sv ====
// ======================================
// Testbench for the execute back-end
// Random RV32I stream, reference model,
// credit and in-order retire checks
// ======================================
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
	import core_pkg::*;
	import rv_isa_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int DMEM_WORDS  = 64;
	localparam int TOTAL_INSTR = 340;	// Sum of all test lengths
	localparam int WATCHDOG_NS = (TOTAL_INSTR * 20 + 16) * 10;

	logic       clk;
	logic       arst_n;
	logic       in_valid;
	instr_req_t in_req;
	logic       credit;
	logic       retire_valid;
	retire_t    retire;

	logic [31:0] rng_state;
	logic [31:0] xr [32];
	logic [31:0] dm [DMEM_WORDS];
	logic [31:0] pc_cnt;
	retire_t     exp_q [$];
	int          credits;
	int          returned;
	int          total_sent;
	int          checks;
	int          errors;
	int          tests;

	exec_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .DMEM_WORDS(DMEM_WORDS)) dut_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_req       (in_req),
		.credit       (credit),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: alu_model = alt ? a - b : a + b;
			3'b001: alu_model = a << b[4:0];
			3'b010: alu_model = {31'b0, $signed(a) < $signed(b)};
			3'b011: alu_model = {31'b0, a < b};
			3'b100: alu_model = a ^ b;
			3'b101: begin
				if (alt)
					alu_model = $signed(a) >>> b[4:0];
				else
					alu_model = a >> b[4:0];
			end
			3'b110: alu_model = a | b;
			default: alu_model = a & b;
		endcase
	endfunction

	// Executes one instruction on the model state, returns its retire record
	function automatic retire_t model_exec(input logic [31:0] pc, input logic [31:0] ins);
		retire_t     r;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] mask;
		logic [7:0]  bsel;
		logic [15:0] hsel;
		logic        wr;
		int          idx;
		int          sh;
		r     = '0;
		r.pc  = pc;
		f3    = ins[14:12];
		a     = xr[ins[19:15]];
		b     = xr[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		val   = '0;
		wr    = 1'b0;
		addr  = a + ((ins[6:0] == 7'h23) ? imm_s : imm_i);
		idx   = int'((addr >> 2) % DMEM_WORDS);
		case (ins[6:0])
			7'h33: begin
				val = alu_model(f3, ins[30], a, b);
				wr  = 1'b1;
			end
			7'h13: begin
				val = alu_model(f3, (f3 == 3'b101) && ins[30], a, imm_i);
				wr  = 1'b1;
			end
			7'h37: begin
				val = {ins[31:12], 12'b0};
				wr  = 1'b1;
			end
			7'h03: begin
				bsel = 8'(dm[idx] >> (8 * int'(addr[1:0])));
				hsel = 16'(dm[idx] >> (16 * int'(addr[1])));
				case (f3)
					3'b000:  val = {{24{bsel[7]}}, bsel};
					3'b001:  val = {{16{hsel[15]}}, hsel};
					3'b100:  val = {24'b0, bsel};
					3'b101:  val = {16'b0, hsel};
					default: val = dm[idx];
				endcase
				wr = 1'b1;
			end
			7'h23: begin
				sh   = (f3 == 3'b000) ? 8 * int'(addr[1:0]) : 16 * int'(addr[1]);
				mask = (f3 == 3'b000) ? 32'hff : 32'hffff;
				if (f3 == 3'b010) begin
					sh   = 0;
					mask = 32'hffff_ffff;
				end
				mask    = mask << sh;
				dm[idx] = (dm[idx] & ~mask) | ((b << sh) & mask);
				r.store = (f3 == 3'b000) ? ST_SB : (f3 == 3'b001) ? ST_SH : ST_SW;
				r.st_addr = addr;
				r.st_data = b;
			end
			7'h63: begin
				case (f3)
					3'b000:  r.jmp_en = (a == b);
					3'b001:  r.jmp_en = (a != b);
					3'b100:  r.jmp_en = ($signed(a) < $signed(b));
					3'b101:  r.jmp_en = ($signed(a) >= $signed(b));
					3'b110:  r.jmp_en = (a < b);
					default: r.jmp_en = (a >= b);
				endcase
				r.jmp_to = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			7'h6f: begin
				r.jmp_en = 1'b1;
				r.jmp_to = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				val      = pc + 32'd4;
				wr       = 1'b1;
			end
			default: begin	// JALR
				r.jmp_en = 1'b1;
				r.jmp_to = (a + imm_i) & ~32'd1;
				val      = pc + 32'd4;
				wr       = 1'b1;
			end
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			r.rd          = ins[11:7];
			r.rd_we       = 1'b1;
			r.rd_value    = val;
			xr[ins[11:7]] = val;
		end
		return r;
	endfunction

	// Kinds: 0 ADDI, 1 LUI, 2 R-type, 3 I-type, 4 load, 5 store, 6 branch, 7 JAL/JALR
	function automatic logic [31:0] gen_instr(input int kind, input int nregs);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [31:0] r;
		logic [11:0] imm12;
		logic [12:0] imm13;
		logic [20:0] imm21;
		rd    = 5'(next_rand() % nregs);
		rs1   = 5'(next_rand() % nregs);
		rs2   = 5'(next_rand() % nregs);
		r     = next_rand();
		f3    = r[2:0];
		imm12 = r[31:20];
		imm13 = {r[31:20], 1'b0};
		imm21 = {r[31:12], 1'b0};
		case (kind)
			0: return {imm12, rs1, 3'b000, rd, 7'h13};
			1: return {r[31:12], rd, 7'h37};
			2: return {1'b0, r[3] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, 7'h33};
			3: begin
				if (f3 == 3'b001)
					imm12 = {7'b0, r[24:20]};
				else if (f3 == 3'b101)
					imm12 = {1'b0, r[3], 5'b0, r[24:20]};
				return {imm12, rs1, f3, rd, 7'h13};
			end
			4: begin
				case (r[7:0] % 5)
					0: f3 = 3'b000;
					1: f3 = 3'b001;
					2: f3 = 3'b010;
					3: f3 = 3'b100;
					default: f3 = 3'b101;
				endcase
				return {imm12, rs1, f3, rd, 7'h03};
			end
			5: return {imm12[11:5], rs2, rs1, 3'(r[7:0] % 3), imm12[4:0], 7'h23};
			6: begin
				f3 = (r[1:0] == 2'b00) ? {2'b00, r[3]} : {1'b1, r[4:3]};
				return {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'h63};
			end
			default: begin
				if (r[0])
					return {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'h6f};
				return {imm12, rs1, 3'b000, rd, 7'h67};
			end
		endcase
	endfunction

	// Checks one cycle of DUT outputs and collects returned credits
	task automatic observe();
		retire_t exp;
		if (credit) begin
			credits++;
			returned++;
		end
		assert (credits <= QUEUE_DEPTH) else begin
			$display("Credit overflow: %0d credits held with depth %0d", credits, QUEUE_DEPTH);
			errors++;
		end
		if (retire_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("Retire at pc %08h arrived with no instruction outstanding", retire.pc);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp = exp_q.pop_front();
				checks++;
				assert (retire == exp) else begin
					$display("[ERROR] %0t: pc %08h got rd x%0d=%08h st %0d %08h/%08h jmp %0b %08h",
						$time, retire.pc, retire.rd, retire.rd_value, retire.store,
						retire.st_addr, retire.st_data, retire.jmp_en, retire.jmp_to);
					$display("        expected pc %08h rd x%0d=%08h st %0d %08h/%08h jmp %0b %08h",
						exp.pc, exp.rd, exp.rd_value, exp.store, exp.st_addr, exp.st_data,
						exp.jmp_en, exp.jmp_to);
					errors++;
				end
			end
		end
	endtask

	task automatic run_test(input string name, input logic [7:0] kinds, input int nregs,
			input int pct, input int count);
		int          sent;
		int          err0;
		int          k;
		logic [31:0] ins;
		sent = 0;
		err0 = errors;
		while (sent < count) begin
			@(negedge clk);
			observe();
			in_valid = 1'b0;
			if (credits > 0 && (next_rand() % 100) < pct) begin
				do
					k = int'(next_rand() % 8);
				while (!kinds[k]);
				ins = gen_instr(k, nregs);
				exp_q.push_back(model_exec(pc_cnt, ins));
				in_req   = {pc_cnt, ins};
				in_valid = 1'b1;
				pc_cnt   += 32'd4;
				credits--;
				sent++;
				total_sent++;
			end
		end
		// Drain, with a few idle cycles to catch late duplicates
		for (int i = 0; i < 40; i++) begin
			@(negedge clk);
			observe();
			in_valid = 1'b0;
			if (i > 2 && exp_q.size() == 0 && credits == QUEUE_DEPTH)
				break;
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d retires missing after test %s", exp_q.size(), name);
			errors++;
		end
		assert (returned == total_sent && credits == QUEUE_DEPTH) else begin
			$display("Credits returned %0d do not match %0d instructions sent", returned, total_sent);
			errors++;
		end
		tests++;
		$display("test %s: %0d instructions, %0d errors", name, count, errors - err0);
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		in_valid   = 1'b0;
		in_req     = '0;
		rng_state  = 32'd66;
		pc_cnt     = 32'h0000_1000;
		credits    = QUEUE_DEPTH;
		returned   = 0;
		total_sent = 0;
		checks     = 0;
		errors     = 0;
		tests      = 0;
		for (int i = 0; i < 32; i++)
			xr[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			dm[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		run_test("alu", 8'b0000_1111, 8, 70, 60);
		run_test("memory", 8'b0011_0011, 8, 50, 60);
		run_test("branch_jump", 8'b1100_0011, 8, 60, 60);
		run_test("dependent_chain", 8'hff, 3, 100, 60);	// x0..x2 only
		run_test("random_burst", 8'hff, 8, 45, 100);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
// ======================================
// Execute back-end top level
// Queue, stage register, bypass, retire
// ======================================
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DMEM_WORDS  = 64
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  core_pkg::instr_req_t in_req,
	output logic                 credit,
	output logic                 retire_valid,
	output core_pkg::retire_t    retire
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	instr_req_t      head;
	logic            head_valid;
	decoded_t        dec;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	ex_out_t         ex_result;

	logic            mem_valid;
	logic [XLEN-1:0] mem_pc;
	ex_out_t         mem_ex;
	logic [XLEN-1:0] load_data;
	logic [XLEN-1:0] wb_value;
	logic            wb_we;

	// Head is popped every cycle the queue holds an entry
	issue_queue #(.DEPTH(QUEUE_DEPTH)) queue_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (in_valid),
		.push_data (in_req),
		.head      (head),
		.not_empty (head_valid),
		.pop       (head_valid)
	);

	assign credit = head_valid;	// One credit back per pop

	decoder dec_i (
		.instr (head.instr),
		.dec   (dec)
	);

	regfile rf_i (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (wb_we),
		.waddr  (mem_ex.rd),
		.wdata  (wb_value)
	);

	// Forward from memory stage, so no stalls
	assign rs1_val = (wb_we && mem_ex.rd != '0 && mem_ex.rd == dec.rs1) ? wb_value : rdata1;
	assign rs2_val = (wb_we && mem_ex.rd != '0 && mem_ex.rd == dec.rs2) ? wb_value : rdata2;

	ex ex_i (
		.pc      (head.pc),
		.dec     (dec),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.result  (ex_result)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem_valid <= 1'b0;
		else
			mem_valid <= head_valid;
	end

	always_ff @(posedge clk) begin
		if (head_valid) begin
			mem_pc <= head.pc;
			mem_ex <= ex_result;
		end
	end

	lsu #(.DMEM_WORDS(DMEM_WORDS)) lsu_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.valid     (mem_valid),
		.ex        (mem_ex),
		.load_data (load_data)
	);

	// Taken branches also set jmp_en but never write rd
	assign wb_value = (mem_ex.load != LD_NONE) ? load_data :
	                  mem_ex.jmp_en ? mem_ex.link : mem_ex.alu_result;
	assign wb_we    = mem_valid && mem_ex.rd_we;

	assign retire_valid = mem_valid;

	always_comb begin
		retire          = '0;
		retire.pc       = mem_pc;
		retire.rd       = mem_ex.rd;
		retire.rd_we    = mem_ex.rd_we;
		retire.rd_value = mem_ex.rd_we ? wb_value : '0;
		retire.store    = mem_ex.store;
		if (mem_ex.store != ST_NONE) begin
			retire.st_addr = mem_ex.alu_result;	// Raw address before wrap
			retire.st_data = mem_ex.st_data;
		end
		retire.jmp_en   = mem_ex.jmp_en;
		retire.jmp_to   = mem_ex.jmp_to;
	end

endmodule

`default_nettype wire

// ==== lsu.sv ====
// ======================================
// Data memory with byte lane access
// ======================================
`timescale 1ns/1ps
`default_nettype none

module lsu #(
	parameter int DMEM_WORDS = 64	// Power of two
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      valid,
	input  core_pkg::ex_out_t         ex,
	output logic [core_pkg::XLEN-1:0] load_data
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [XLEN-1:0]  mem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [1:0]       off;
	logic [XLEN-1:0]  rd_word;
	logic [7:0]       rd_byte;
	logic [15:0]      rd_half;

	assign idx = ex.alu_result[IDX_W+1:2];	// Wraps modulo the memory size
	assign off = ex.alu_result[1:0];

	// Halfword lanes use only off[1] and words ignore off, which aligns down
	assign rd_word = mem[idx];
	assign rd_byte = rd_word[{off, 3'b000} +: 8];
	assign rd_half = rd_word[{off[1], 4'b0000} +: 16];

	always_comb begin
		case (ex.load)
			LD_LB:   load_data = {{24{rd_byte[7]}}, rd_byte};
			LD_LH:   load_data = {{16{rd_half[15]}}, rd_half};
			LD_LW:   load_data = rd_word;
			LD_LBU:  load_data = {24'b0, rd_byte};
			LD_LHU:  load_data = {16'b0, rd_half};
			default: load_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (valid) begin
			case (ex.store)
				ST_SB:   mem[idx][{off, 3'b000} +: 8] <= ex.st_data[7:0];
				ST_SH:   mem[idx][{off[1], 4'b0000} +: 16] <= ex.st_data[15:0];
				ST_SW:   mem[idx] <= ex.st_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== ex.sv ====
// ======================================
// ALU, branch compare and jump target
// ======================================
`timescale 1ns/1ps
`default_nettype none

module ex (
	input  logic [core_pkg::XLEN-1:0] pc,
	input  core_pkg::decoded_t        dec,
	input  logic [core_pkg::XLEN-1:0] rs1_val,
	input  logic [core_pkg::XLEN-1:0] rs2_val,
	output core_pkg::ex_out_t         result
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] sra_fill;
	logic            eq;
	logic            lt;
	logic            ltu;
	logic [XLEN-1:0] alu_out;
	logic            take;
	logic [XLEN-1:0] target;

	assign op_a  = dec.use_pc ? pc : rs1_val;
	assign op_b  = dec.use_imm ? dec.imm : rs2_val;
	assign shamt = op_b[4:0];

	// Sign bits shifted in from the top for SRA
	assign sra_fill = ~({XLEN{1'b1}} >> shamt) & {XLEN{op_a[XLEN-1]}};

	assign eq  = (op_a == op_b);
	assign lt  = ($signed(op_a) < $signed(op_b));
	assign ltu = (op_a < op_b);

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << shamt;
			ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, lt};
			ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, ltu};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> shamt;
			ALU_SRA:    alu_out = (op_a >> shamt) | sra_fill;
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;	// LUI
			default:    alu_out = '0;
		endcase
	end

	always_comb begin
		case (dec.jmp)
			JMP_BRANCH: begin
				case (dec.br)
					BR_BEQ:  take = eq;
					BR_BNE:  take = !eq;
					BR_BLT:  take = lt;
					BR_BGE:  take = !lt;
					BR_BLTU: take = ltu;
					BR_BGEU: take = !ltu;
					default: take = 1'b0;
				endcase
			end
			JMP_JAL, JMP_JALR: take = 1'b1;
			default:           take = 1'b0;
		endcase
	end

	// JAL and JALR targets come out of the ALU adder
	always_comb begin
		case (dec.jmp)
			JMP_BRANCH: target = pc + dec.imm;
			JMP_JAL:    target = alu_out;
			JMP_JALR:   target = {alu_out[XLEN-1:1], 1'b0};
			default:    target = '0;
		endcase
	end

	always_comb begin
		result            = '0;
		result.alu_result = alu_out;
		result.st_data    = rs2_val;
		result.load       = dec.load;
		result.store      = dec.store;
		result.rd         = dec.rd;
		result.rd_we      = dec.rd_we;
		result.jmp_en     = take;
		result.jmp_to     = target;
		result.link       = pc + XLEN'(4);
	end

endmodule

`default_nettype wire

// ==== regfile.sv ====
// ======================================
// Register file, x0 fixed at zero
// ======================================
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs2,
	output logic [core_pkg::XLEN-1:0]       rdata1,
	output logic [core_pkg::XLEN-1:0]       rdata2,
	input  logic                            we,
	input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [core_pkg::XLEN-1:0]       wdata
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== decoder.sv ====
// ======================================
// RV32I decoder with immediate build
// ======================================
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  logic [31:0]        instr,
	output core_pkg::decoded_t dec
);
	import core_pkg::*;
	import rv_isa_pkg::*;

	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_u;
	logic [2:0]      funct3;
	logic            alt;

	assign funct3 = instr[14:12];
	assign alt    = (instr[31:25] == F7_ALT);

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub_en,
			input logic sra_en);
		case (funct3_e'(f3))
			F3_ADD:  return sub_en ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return sra_en ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	always_comb begin
		dec     = '0;
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		case (opcode_e'(instr[6:0]))
			OPC_OP: begin
				dec.alu_op = alu_sel(funct3, alt, alt);
				dec.rd_we  = 1'b1;
			end
			OPC_OP_IMM: begin
				dec.alu_op  = alu_sel(funct3, 1'b0, alt);	// No SUBI
				dec.imm     = imm_i;
				dec.use_imm = 1'b1;
				dec.rd_we   = 1'b1;
			end
			OPC_LOAD: begin
				case (funct3)
					3'b000:  dec.load = LD_LB;
					3'b001:  dec.load = LD_LH;
					3'b010:  dec.load = LD_LW;
					3'b100:  dec.load = LD_LBU;
					3'b101:  dec.load = LD_LHU;
					default: dec.load = LD_NONE;
				endcase
				dec.imm     = imm_i;
				dec.use_imm = 1'b1;
				dec.rd_we   = (dec.load != LD_NONE);
			end
			OPC_STORE: begin
				case (funct3)
					3'b000:  dec.store = ST_SB;
					3'b001:  dec.store = ST_SH;
					3'b010:  dec.store = ST_SW;
					default: dec.store = ST_NONE;
				endcase
				dec.imm     = imm_s;
				dec.use_imm = 1'b1;
			end
			OPC_BRANCH: begin
				dec.jmp = JMP_BRANCH;
				dec.br  = branch_e'(funct3);
				dec.imm = imm_b;	// Compares use rs1 and rs2
			end
			OPC_JAL: begin
				dec.jmp     = JMP_JAL;
				dec.imm     = imm_j;
				dec.use_pc  = 1'b1;
				dec.use_imm = 1'b1;
				dec.rd_we   = 1'b1;
			end
			OPC_JALR: begin
				dec.jmp     = JMP_JALR;
				dec.imm     = imm_i;
				dec.use_imm = 1'b1;
				dec.rd_we   = 1'b1;
			end
			OPC_LUI: begin
				dec.alu_op  = ALU_PASS_B;
				dec.imm     = imm_u;
				dec.use_imm = 1'b1;
				dec.rd_we   = 1'b1;
			end
			default: ;
		endcase
		// Writes to x0 become no-write operations
		if (dec.rd_we && instr[11:7] != '0)
			dec.rd = instr[11:7];
		else
			dec.rd_we = 1'b0;
	end

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
// ======================================
// Circular FIFO of incoming instructions
// ======================================
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
	parameter int DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 push,
	input  core_pkg::instr_req_t push_data,
	output core_pkg::instr_req_t head,
	output logic                 not_empty,
	input  logic                 pop
);
	import core_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	instr_req_t       slots [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign do_pop    = pop && not_empty;
	assign head      = slots[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;	// Idle or push and pop together
			endcase
		end
	end

	// Sender credits guarantee a free slot on push
	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
// ======================================
// Pipeline widths and stage structs
// ======================================
`default_nettype none

package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     instr;
	} instr_req_t;

	typedef struct packed {
		rv_isa_pkg::alu_op_e   alu_op;
		rv_isa_pkg::load_e     load;
		rv_isa_pkg::store_e    store;
		rv_isa_pkg::jmp_e      jmp;
		rv_isa_pkg::branch_e   br;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_we;
		logic [XLEN-1:0]       imm;
		logic                  use_imm;	// Operand b is imm instead of rs2
		logic                  use_pc;	// Operand a is pc instead of rs1
	} decoded_t;

	typedef struct packed {
		logic [XLEN-1:0]       alu_result;
		logic [XLEN-1:0]       st_data;
		rv_isa_pkg::load_e     load;
		rv_isa_pkg::store_e    store;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_we;
		logic                  jmp_en;
		logic [XLEN-1:0]       jmp_to;
		logic [XLEN-1:0]       link;	// pc+4
	} ex_out_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_we;
		logic [XLEN-1:0]       rd_value;
		rv_isa_pkg::store_e    store;
		logic [XLEN-1:0]       st_addr;
		logic [XLEN-1:0]       st_data;
		logic                  jmp_en;
		logic [XLEN-1:0]       jmp_to;
	} retire_t;

endpackage

`default_nettype wire

// ==== rv_isa_pkg.sv ====
// ======================================
// RV32I opcode, funct3 and funct7 codes
// Internal ALU, load, store, jump codes
// ======================================
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// ALU funct3 for OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} funct3_e;

	typedef enum logic [6:0] {
		F7_BASE = 7'b0000000,
		F7_ALT  = 7'b0100000	// SUB and SRA
	} funct7_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {LD_NONE, LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU} load_e;

	typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_e;

	typedef enum logic [1:0] {JMP_NONE, JMP_BRANCH, JMP_JAL, JMP_JALR} jmp_e;

	// Values equal the branch funct3
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_e;

endpackage

`default_nettype wire
